//--- tb/backend_input.txt
# pc alu_op src1 src2 store_data dest gr_we mem_we res_from_mem (hex)
# then expected exp_pc rf_we wnum wdata
00001000 0 00000005 00000007 00000000 01 1 0 0 00001000 1 01 0000000c
00001004 1 00000003 00000005 00000000 02 1 0 0 00001004 1 02 fffffffe
00001008 2 f0f0ff00 0ff0f0f0 00000000 03 1 0 0 00001008 1 03 00f0f000
0000100c 3 f0f00000 000f000f 00000000 04 1 0 0 0000100c 1 04 f0ff000f
00001010 4 ffff0000 0f0f0f0f 00000000 05 1 0 0 00001010 1 05 f0f00f0f
00001014 5 ffffffff 00000001 00000000 06 1 0 0 00001014 1 06 00000001
00001018 6 ffffffff 00000001 00000000 07 1 0 0 00001018 1 07 00000000
0000101c 7 00000003 00000024 00000000 08 1 0 0 0000101c 1 08 00000030
00001020 8 80000000 0000003f 00000000 09 1 0 0 00001020 1 09 00000001
00001024 0 00000100 00000008 deadbeef 00 0 1 0 00001024 0 00 00000000
00001028 0 00000200 0000000c 12345678 00 0 1 0 00001028 0 00 00000000
0000102c 0 0000000a 00000014 00000000 0a 1 0 0 0000102c 1 0a 0000001e
00001030 0 00000100 00000008 00000000 0b 1 0 1 00001030 1 0b deadbeef
00001034 0 00000200 0000000c 00000000 0c 1 0 1 00001034 1 0c 12345678
00001038 5 80000000 7fffffff 00000000 0d 1 0 0 00001038 1 0d 00000001
0000103c 6 80000000 7fffffff 00000000 0e 1 0 0 0000103c 1 0e 00000000

//--- flist.f
+incdir+source
source/cpu_pkg.sv
source/exe_stage.sv
source/mem_stage.sv
source/wb_stage.sv
source/data_sram.sv
source/cpu_backend_top.sv
tb/cpu_backend_assertions.sv
tb/cpu_backend_tb.sv

//--- Makefile
TOP = cpu_backend_tb

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f \
		--Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee sim.log
	@if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then exit 1; fi
	@grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- tb/cpu_backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_backend_tb;

    localparam int MAX_OPS = 64;
    localparam int TIMEOUT = 200;

    logic                clk;
    logic                reset;
    logic                in_valid;
    cpu_pkg::word_t      in_pc;
    cpu_pkg::alu_op_t    in_alu_op;
    cpu_pkg::word_t      in_src1;
    cpu_pkg::word_t      in_src2;
    cpu_pkg::word_t      in_store_data;
    cpu_pkg::reg_addr_t  in_dest;
    logic                in_gr_we;
    logic                in_mem_we;
    logic                in_res_from_mem;
    logic                es_allowin;
    logic                wb_stall;
    cpu_pkg::word_t      debug_wb_pc;
    logic                debug_wb_rf_we;
    cpu_pkg::reg_addr_t  debug_wb_rf_wnum;
    cpu_pkg::word_t      debug_wb_rf_wdata;
    cpu_pkg::reg_addr_t  mem_fwd_dest;
    logic                mem_fwd_we;
    cpu_pkg::word_t      mem_fwd_result;

    // Operation records from the stimulus file
    cpu_pkg::word_t      op_pc     [MAX_OPS];
    cpu_pkg::alu_op_t    op_alu    [MAX_OPS];
    cpu_pkg::word_t      op_src1   [MAX_OPS];
    cpu_pkg::word_t      op_src2   [MAX_OPS];
    cpu_pkg::word_t      op_sdata  [MAX_OPS];
    cpu_pkg::reg_addr_t  op_dest   [MAX_OPS];
    logic                op_gr_we  [MAX_OPS];
    logic                op_mem_we [MAX_OPS];
    logic                op_rfm    [MAX_OPS];
    cpu_pkg::word_t      exp_pc    [MAX_OPS];
    logic                exp_we    [MAX_OPS];
    cpu_pkg::reg_addr_t  exp_wnum  [MAX_OPS];
    cpu_pkg::word_t      exp_wdata [MAX_OPS];
    int                  n_ops = 0;

    int  exp_q [$];                                      // Record index per accepted op
    int  acc_q [$];                                      // Accept edge per accepted op
    int  cycle = 0;
    int  last_stall_cycle = -1;
    int  errors = 0;
    int  checks = 0;
    bit  stall_en = 0;
    bit  timing_en = 0;
    bit  timed_out = 0;

    cpu_backend_top dut0 (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    always @(posedge clk) begin
        #2;
        wb_stall = stall_en && ($urandom % 4 == 0);      // Roughly one stalled cycle in four
    end

    task automatic check_word(input cpu_pkg::word_t got, input cpu_pkg::word_t exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(input cpu_pkg::reg_addr_t got, input cpu_pkg::reg_addr_t exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // A store shows up only as a pc change in writeback, so it is matched by pc
    always @(negedge clk) begin : trace_monitor
        int  idx;
        int  acc;
        bit  retire;
        if (!reset) begin
            if (wb_stall) last_stall_cycle = cycle;
            if (debug_wb_rf_we && wb_stall) begin
                errors++;
                $display("ERR %0t: retirement of pc %h while stalled", $time, debug_wb_pc);
            end
            retire = debug_wb_rf_we;
            if (!retire && exp_q.size() > 0 && !wb_stall)
                retire = !exp_we[exp_q[0]] && (debug_wb_pc === exp_pc[exp_q[0]]);
            if (retire && exp_q.size() == 0) begin
                errors++;
                $display("Unexpected retirement of pc %h with nothing outstanding",
                         debug_wb_pc);
            end else if (retire) begin
                idx = exp_q.pop_front();
                acc = acc_q.pop_front();
                check_word(debug_wb_pc, exp_pc[idx], "debug_wb_pc");
                check_bit(debug_wb_rf_we, exp_we[idx], "debug_wb_rf_we");
                if (exp_we[idx]) begin
                    check_reg(debug_wb_rf_wnum, exp_wnum[idx], "debug_wb_rf_wnum");
                    check_word(debug_wb_rf_wdata, exp_wdata[idx], "debug_wb_rf_wdata");
                end
                if (timing_en && last_stall_cycle < acc && cycle != acc + 2) begin
                    errors++;
                    $display("ERR %0t: pc %h retired %0d edges after accept, expected 2",
                             $time, debug_wb_pc, cycle - acc);
                end
            end
        end
    end

    // Without stalls the memory stage holds the op accepted one edge earlier
    always @(negedge clk) begin : fwd_monitor
        int  idx;
        idx = -1;
        if (!reset && timing_en) begin
            foreach (acc_q[i]) begin
                if (acc_q[i] == cycle - 1) idx = exp_q[i];
            end
            if (idx < 0) begin
                check_bit(mem_fwd_we, 1'b0, "mem_fwd_we with memory stage empty");
                check_reg(mem_fwd_dest, '0, "mem_fwd_dest with memory stage empty");
            end else begin
                check_bit(mem_fwd_we, exp_we[idx], "mem_fwd_we");
                if (exp_we[idx]) begin
                    check_reg(mem_fwd_dest, exp_wnum[idx], "mem_fwd_dest");
                    check_word(mem_fwd_result, exp_wdata[idx], "mem_fwd_result");
                end
            end
        end
    end

    task automatic load_ops;
        int     fd;
        int     n;
        string  line;
        fd = $fopen("tb/backend_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open stimulus file tb/backend_input.txt");
        end else begin
            while (!$feof(fd) && n_ops < MAX_OPS) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                op_pc[n_ops], op_alu[n_ops], op_src1[n_ops],
                                op_src2[n_ops], op_sdata[n_ops], op_dest[n_ops],
                                op_gr_we[n_ops], op_mem_we[n_ops], op_rfm[n_ops],
                                exp_pc[n_ops], exp_we[n_ops], exp_wnum[n_ops],
                                exp_wdata[n_ops]);
                    if (n == 13) begin
                        n_ops++;
                    end else begin
                        errors++;
                        $display("Malformed line in stimulus file: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Called 2 ns after a rising edge and returns at the same phase
    task automatic issue_op(input int idx);
        int waited;
        in_valid        = 1'b1;
        in_pc           = op_pc[idx];
        in_alu_op       = op_alu[idx];
        in_src1         = op_src1[idx];
        in_src2         = op_src2[idx];
        in_store_data   = op_sdata[idx];
        in_dest         = op_dest[idx];
        in_gr_we        = op_gr_we[idx];
        in_mem_we       = op_mem_we[idx];
        in_res_from_mem = op_rfm[idx];
        waited = 0;
        @(negedge clk);
        while (!es_allowin && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!es_allowin) begin
            timed_out = 1;
            $display("Timeout: es_allowin stayed low for %0d cycles", TIMEOUT);
        end else begin
            exp_q.push_back(idx);
            acc_q.push_back(cycle + 1);
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic run_pass(input bit gaps);
        for (int i = 0; i < n_ops && !timed_out; i++) begin
            issue_op(i);
            if (gaps) begin
                repeat ($urandom % 3) begin
                    @(posedge clk);
                    #2;
                end
            end
        end
    endtask

    task automatic drain;
        int idle;
        int last_size;
        idle = 0;
        last_size = exp_q.size();
        while (exp_q.size() > 0 && idle < TIMEOUT) begin
            @(negedge clk);
            if (exp_q.size() != last_size) idle = 0;
            else idle++;
            last_size = exp_q.size();
        end
        if (exp_q.size() > 0) begin
            timed_out = 1;
            $display("Timeout: %0d operations never retired", exp_q.size());
        end
        @(posedge clk);
        #2;
    endtask

    initial begin
        int seed_dummy;
        seed_dummy = $urandom(32'h617a);
        reset = 1'b1;
        wb_stall = 1'b0;
        in_valid = 1'b0;
        in_pc = '0;
        in_alu_op = '0;
        in_src1 = '0;
        in_src2 = '0;
        in_store_data = '0;
        in_dest = '0;
        in_gr_we = 1'b0;
        in_mem_we = 1'b0;
        in_res_from_mem = 1'b0;
        load_ops();
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        check_bit(es_allowin, 1'b1, "es_allowin after reset");
        check_bit(debug_wb_rf_we, 1'b0, "debug_wb_rf_we after reset");
        check_bit(mem_fwd_we, 1'b0, "mem_fwd_we after reset");
        @(posedge clk);
        #2;
        timing_en = 1;                                   // Back-to-back, no stall
        run_pass(0);
        drain();
        timing_en = 0;
        if (!timed_out) begin
            run_pass(1);
            drain();
        end
        if (!timed_out) begin
            stall_en = 1;
            run_pass(1);
            drain();
            stall_en = 0;
        end
        $display("Summary: %0d operations, %0d checks, %0d errors", n_ops, checks, errors);
        if (errors == 0 && !timed_out && n_ops > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/cpu_backend_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_backend_assertions (
    input wire clk,
    input wire reset,
    input wire data_sram_en,
    input wire es_to_ms_valid,
    input wire ms_allowin,
    input wire es_allowin,
    input wire wb_stall,
    input wire debug_wb_rf_we,
    input wire mem_fwd_we
);

    // The RAM is only touched when execute hands its operation to memory
    sram_on_transfer: assert property (@(posedge clk) disable iff (reset)
        data_sram_en |-> (es_to_ms_valid && ms_allowin))
        else $error("data_sram_en raised without an execute to memory transfer");

    no_commit_when_stalled: assert property (@(posedge clk) disable iff (reset)
        wb_stall |-> !debug_wb_rf_we)
        else $error("debug_wb_rf_we high while wb_stall is high");

    clean_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (es_allowin && !debug_wb_rf_we && !mem_fwd_we && !data_sram_en))
        else $error("Pipeline not empty right after reset");

endmodule

bind cpu_backend_top cpu_backend_assertions asrt0 (
    .clk            (clk),
    .reset          (reset),
    .data_sram_en   (data_sram_en),
    .es_to_ms_valid (es_to_ms_valid),
    .ms_allowin     (ms_allowin),
    .es_allowin     (es_allowin),
    .wb_stall       (wb_stall),
    .debug_wb_rf_we (debug_wb_rf_we),
    .mem_fwd_we     (mem_fwd_we)
);

`default_nettype wire

//--- source/cpu_backend_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_backend_top (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 in_valid,
    input  cpu_pkg::word_t      in_pc,
    input  cpu_pkg::alu_op_t    in_alu_op,
    input  cpu_pkg::word_t      in_src1,
    input  cpu_pkg::word_t      in_src2,
    input  cpu_pkg::word_t      in_store_data,
    input  cpu_pkg::reg_addr_t  in_dest,
    input  wire                 in_gr_we,
    input  wire                 in_mem_we,
    input  wire                 in_res_from_mem,
    output logic                es_allowin,
    input  wire                 wb_stall,
    output cpu_pkg::word_t      debug_wb_pc,
    output logic                debug_wb_rf_we,
    output cpu_pkg::reg_addr_t  debug_wb_rf_wnum,
    output cpu_pkg::word_t      debug_wb_rf_wdata,
    output cpu_pkg::reg_addr_t  mem_fwd_dest,
    output logic                mem_fwd_we,
    output cpu_pkg::word_t      mem_fwd_result
);

    logic                ms_allowin;
    logic                ws_allowin;

    logic                es_to_ms_valid;
    cpu_pkg::word_t      es_pc;
    cpu_pkg::reg_addr_t  es_dest;
    logic                es_gr_we;
    logic                es_res_from_mem;
    cpu_pkg::word_t      es_alu_result;

    logic                ms_to_ws_valid;
    cpu_pkg::word_t      ms_pc;
    cpu_pkg::reg_addr_t  ms_dest;
    logic                ms_gr_we;
    cpu_pkg::word_t      ms_final_result;

    logic                data_sram_en;
    logic                data_sram_we;
    cpu_pkg::ram_addr_t  data_sram_addr;
    cpu_pkg::word_t      data_sram_wdata;
    cpu_pkg::word_t      data_sram_rdata;

    exe_stage exe_stage0 (.*);

    mem_stage mem_stage0 (.*);

    wb_stage wb_stage0 (.*);

    data_sram data_sram0 (
        .clk   (clk),
        .en    (data_sram_en),
        .we    (data_sram_we),
        .addr  (data_sram_addr),
        .wdata (data_sram_wdata),
        .rdata (data_sram_rdata)
    );

endmodule

`default_nettype wire

//--- source/data_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module data_sram (
    input  wire                 clk,
    input  wire                 en,
    input  wire                 we,
    input  cpu_pkg::ram_addr_t  addr,
    input  cpu_pkg::word_t      wdata,
    output cpu_pkg::word_t      rdata
);

    localparam int DEPTH = 1 << `RAM_AW;

    cpu_pkg::word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
                rdata     <= wdata;                      // Write-first
            end else begin
                rdata     <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 ms_to_ws_valid,
    input  cpu_pkg::word_t      ms_pc,
    input  cpu_pkg::reg_addr_t  ms_dest,
    input  wire                 ms_gr_we,
    input  cpu_pkg::word_t      ms_final_result,
    output logic                ws_allowin,
    input  wire                 wb_stall,
    output cpu_pkg::word_t      debug_wb_pc,
    output logic                debug_wb_rf_we,
    output cpu_pkg::reg_addr_t  debug_wb_rf_wnum,
    output cpu_pkg::word_t      debug_wb_rf_wdata
);

    logic                ws_valid;
    logic                ws_ready_go;
    cpu_pkg::word_t      ws_pc;
    cpu_pkg::reg_addr_t  ws_dest;
    logic                ws_gr_we;
    cpu_pkg::word_t      ws_result;

    // Last stage, so nothing downstream can refuse the operation
    assign ws_ready_go = !wb_stall;
    assign ws_allowin  = !ws_valid || ws_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_pc     <= ms_pc;
            ws_dest   <= ms_dest;
            ws_gr_we  <= ms_gr_we;
            ws_result <= ms_final_result;
        end
    end

    // Write enable pulses once, in the cycle the operation commits
    assign debug_wb_rf_we    = ws_valid && ws_ready_go && ws_gr_we;
    assign debug_wb_pc       = ws_pc;
    assign debug_wb_rf_wnum  = ws_dest;
    assign debug_wb_rf_wdata = ws_result;

endmodule

`default_nettype wire

//--- source/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module mem_stage (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 es_to_ms_valid,
    input  cpu_pkg::word_t      es_pc,
    input  cpu_pkg::reg_addr_t  es_dest,
    input  wire                 es_gr_we,
    input  wire                 es_res_from_mem,
    input  cpu_pkg::word_t      es_alu_result,
    output logic                ms_allowin,
    input  wire                 ws_allowin,
    output logic                ms_to_ws_valid,
    output cpu_pkg::word_t      ms_pc,
    output cpu_pkg::reg_addr_t  ms_dest,
    output logic                ms_gr_we,
    output cpu_pkg::word_t      ms_final_result,
    input  cpu_pkg::word_t      data_sram_rdata,
    output cpu_pkg::reg_addr_t  mem_fwd_dest,
    output logic                mem_fwd_we,
    output cpu_pkg::word_t      mem_fwd_result
);

    logic            ms_valid;
    logic            ms_ready_go;
    logic            ms_res_from_mem;
    cpu_pkg::word_t  ms_alu_result;

    assign ms_ready_go    = 1'b1;                        // RAM data is already registered
    assign ms_allowin     = !ms_valid || (ms_ready_go && ws_allowin);
    assign ms_to_ws_valid = ms_valid && ms_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_pc           <= es_pc;
            ms_dest         <= es_dest;
            ms_gr_we        <= es_gr_we;
            ms_res_from_mem <= es_res_from_mem;
            ms_alu_result   <= es_alu_result;
        end
    end

    // RAM read data stays put while the stage is held
    assign ms_final_result = ms_res_from_mem ? data_sram_rdata : ms_alu_result;

    // An empty stage must not look like a pending register write
    assign mem_fwd_dest   = ms_dest & {`REG_AW{ms_valid}};
    assign mem_fwd_we     = ms_valid && ms_gr_we;
    assign mem_fwd_result = ms_final_result;

endmodule

`default_nettype wire

//--- source/exe_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module exe_stage (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 in_valid,
    input  cpu_pkg::word_t      in_pc,
    input  cpu_pkg::alu_op_t    in_alu_op,
    input  cpu_pkg::word_t      in_src1,
    input  cpu_pkg::word_t      in_src2,
    input  cpu_pkg::word_t      in_store_data,
    input  cpu_pkg::reg_addr_t  in_dest,
    input  wire                 in_gr_we,
    input  wire                 in_mem_we,
    input  wire                 in_res_from_mem,
    output logic                es_allowin,
    input  wire                 ms_allowin,
    output logic                es_to_ms_valid,
    output cpu_pkg::word_t      es_pc,
    output cpu_pkg::reg_addr_t  es_dest,
    output logic                es_gr_we,
    output logic                es_res_from_mem,
    output cpu_pkg::word_t      es_alu_result,
    output logic                data_sram_en,
    output logic                data_sram_we,
    output cpu_pkg::ram_addr_t  data_sram_addr,
    output cpu_pkg::word_t      data_sram_wdata
);

    logic               es_valid;
    logic               es_ready_go;
    cpu_pkg::alu_op_t   es_alu_op;
    cpu_pkg::word_t     es_src1;
    cpu_pkg::word_t     es_src2;
    cpu_pkg::word_t     es_store_data;
    logic               es_mem_we;
    logic               es_to_ms_fire;

    assign es_ready_go    = 1'b1;                        // ALU finishes in one cycle
    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;
    assign es_to_ms_fire  = es_to_ms_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= in_valid;
        end
    end

    // Operation fields are loaded only when a new operation is taken
    always_ff @(posedge clk) begin
        if (in_valid && es_allowin) begin
            es_pc           <= in_pc;
            es_alu_op       <= in_alu_op;
            es_src1         <= in_src1;
            es_src2         <= in_src2;
            es_store_data   <= in_store_data;
            es_dest         <= in_dest;
            es_gr_we        <= in_gr_we;
            es_mem_we       <= in_mem_we;
            es_res_from_mem <= in_res_from_mem;
        end
    end

    always_comb begin
        case (es_alu_op)
            `ALU_ADD:  es_alu_result = es_src1 + es_src2;
            `ALU_SUB:  es_alu_result = es_src1 - es_src2;
            `ALU_AND:  es_alu_result = es_src1 & es_src2;
            `ALU_OR:   es_alu_result = es_src1 | es_src2;
            `ALU_XOR:  es_alu_result = es_src1 ^ es_src2;
            `ALU_SLT: begin
                es_alu_result = {{(`DATA_W-1){1'b0}},
                                 ($signed(es_src1) < $signed(es_src2))};
            end
            `ALU_SLTU: begin
                es_alu_result = {{(`DATA_W-1){1'b0}}, (es_src1 < es_src2)};
            end
            `ALU_SLL:  es_alu_result = es_src1 << es_src2[4:0];
            `ALU_SRL:  es_alu_result = es_src1 >> es_src2[4:0];
            default:   es_alu_result = '0;
        endcase
    end

    // A held store must not write again, so the request goes out only on transfer
    assign data_sram_en    = es_to_ms_fire && (es_mem_we || es_res_from_mem);
    assign data_sram_we    = es_mem_we;
    assign data_sram_addr  = es_alu_result[`RAM_AW+1:2]; // Word index
    assign data_sram_wdata = es_store_data;

endmodule

`default_nettype wire

//--- source/cpu_pkg.sv
`default_nettype none

`include "cpu_consts.svh"

package cpu_pkg;

    // Data word or pc value
    typedef logic [`DATA_W-1:0] word_t;

    // Destination register number
    typedef logic [`REG_AW-1:0] reg_addr_t;

    typedef logic [`ALU_OP_W-1:0] alu_op_t;

    // Word index into the data RAM
    typedef logic [`RAM_AW-1:0] ram_addr_t;

endpackage

`default_nettype wire

//--- source/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Machine widths
`define DATA_W    32
`define REG_AW    5
`define ALU_OP_W  4
`define RAM_AW    8

// ALU operation codes
`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_AND   4'd2
`define ALU_OR    4'd3
`define ALU_XOR   4'd4
`define ALU_SLT   4'd5
`define ALU_SLTU  4'd6
`define ALU_SLL   4'd7
`define ALU_SRL   4'd8

`endif
